// File: hdl/boothPkg.sv
package boothPkg;

	// operand and product sizes
	localparam int OperandWidth = 8;
	localparam int ProductWidth = 2 * OperandWidth;

	// radix-4 retires two multiplier bits per step
	localparam int StepCount = OperandWidth / 2;
	localparam int StepWidth = $clog2(StepCount + 1);

	// high half carries two extra sign bits for the doubled multiplicand
	localparam int AccWidth = OperandWidth + 2;

	// sequencer state encodings
	localparam int StateWidth = 3;
	localparam logic [StateWidth-1:0] stateIdle  = 3'd0;
	localparam logic [StateWidth-1:0] stateLoad  = 3'd1;
	localparam logic [StateWidth-1:0] stateAccum = 3'd2;
	localparam logic [StateWidth-1:0] stateShift = 3'd3;
	localparam logic [StateWidth-1:0] stateDone  = 3'd4;

	typedef logic signed [OperandWidth-1:0] operand_t;

	// bit 0 selects subtract, bit 1 selects the doubled multiplicand
	typedef enum logic [1:0] {
		addOne = 2'b00,
		subOne = 2'b01,
		addTwo = 2'b10,
		subTwo = 2'b11
	} boothAction_t;

	typedef struct packed {
		logic [OperandWidth-1:0] high;
		logic [OperandWidth-1:0] low;
	} productBytes_t;

	// same product word, seen whole or as two bytes
	typedef union packed {
		logic signed [ProductWidth-1:0] full;
		productBytes_t bytes;
	} product_t;

endpackage

// File: hdl/busPkg.sv
package busPkg;

	localparam int DataWidth = 32;
	localparam int AddrWidth = 5;

	// register map
	localparam logic [AddrWidth-1:0] regOperandA    = 5'h00;
	localparam logic [AddrWidth-1:0] regOperandB    = 5'h04;
	// bit 0 starts a multiplication
	localparam logic [AddrWidth-1:0] regControl     = 5'h08;
	// bit 0 busy, bit 1 sticky done
	localparam logic [AddrWidth-1:0] regStatus      = 5'h0C;
	localparam logic [AddrWidth-1:0] regProduct     = 5'h10;
	localparam logic [AddrWidth-1:0] regProductHigh = 5'h14;
	localparam logic [AddrWidth-1:0] regProductLow  = 5'h18;

	typedef enum logic [1:0] {
		respOkay   = 2'b00,
		respSlvErr = 2'b10
	} axiResp_t;

endpackage

// File: hdl/boothControl.sv
`timescale 1ns/1ps

module boothControl import boothPkg::*; (
	input logic CLK,
	input logic RESET,
	input logic start,
	input logic [2:0] window,
	output logic load,
	output logic accumulate,
	output logic shift,
	output logic busy,
	output logic done,
	output boothAction_t action
);

	logic [StateWidth-1:0] state;
	logic [StateWidth-1:0] stateNext;
	logic [StepWidth-1:0] stepCnt;
	logic [StepWidth-1:0] stepInc;
	logic nonZero;

	assign stepInc = stepCnt + 1'b1;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			state <= stateIdle;
			stepCnt <= '0;
		end else begin
			state <= stateNext;
			// step counter, restarted at load and advanced per shift
			if (load) begin
				stepCnt <= '0;
			end else if (shift) begin
				stepCnt <= stepInc;
			end
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			stateIdle: begin
				if (start) begin
					stateNext = stateLoad;
				end
			end
			stateLoad: begin
				stateNext = stateAccum;
			end
			stateAccum: begin
				stateNext = stateShift;
			end
			stateShift: begin
				// last shift once every multiplier pair has been retired
				if (stepInc == StepWidth'(StepCount)) begin
					stateNext = stateDone;
				end else begin
					stateNext = stateAccum;
				end
			end
			stateDone: begin
				stateNext = stateIdle;
			end
			default: begin
				stateNext = stateIdle;
			end
		endcase
	end

	// radix-4 recoding of {b[i+1], b[i], b[i-1]}
	always_comb begin
		action = addOne;
		nonZero = 1'b1;
		case (window)
			3'b001, 3'b010: action = addOne;
			3'b011: action = addTwo;
			3'b100: action = subTwo;
			3'b101, 3'b110: action = subOne;
			default: nonZero = 1'b0;
		endcase
	end

	assign load = (state == stateLoad);
	// 000 and 111 leave the partial product alone
	assign accumulate = (state == stateAccum) && nonZero;
	assign shift = (state == stateShift);
	assign done = (state == stateDone);
	assign busy = (state != stateIdle);

endmodule

// File: hdl/boothDatapath.sv
`timescale 1ns/1ps

module boothDatapath import boothPkg::*; (
	input logic CLK,
	input logic RESET,
	input logic load,
	input logic accumulate,
	input logic shift,
	input boothAction_t action,
	input operand_t operandA,
	input operand_t operandB,
	output logic [2:0] window,
	output product_t product
);

	operand_t multiplicand;
	logic signed [AccWidth-1:0] accHigh;
	logic [OperandWidth-1:0] accLow;
	logic guard;

	logic signed [AccWidth-1:0] addend;
	logic signed [AccWidth-1:0] sum;
	logic signed [AccWidth+OperandWidth:0] shifted;

	// multiplicand, sign extended, either once or doubled
	always_comb begin
		case (action)
			addTwo, subTwo: begin
				addend = {
					{(AccWidth-OperandWidth-1){multiplicand[OperandWidth-1]}},
					multiplicand,
					1'b0
				};
			end
			default: begin
				addend = {
					{(AccWidth-OperandWidth){multiplicand[OperandWidth-1]}},
					multiplicand
				};
			end
		endcase
	end

	always_comb begin
		if (action == subOne || action == subTwo) begin
			sum = accHigh - addend;
		end else begin
			sum = accHigh + addend;
		end
	end

	// whole register including guard bit moves right by one multiplier pair
	assign shifted = $signed({accHigh, accLow, guard}) >>> 2;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			multiplicand <= '0;
			accHigh <= '0;
			accLow <= '0;
			guard <= 1'b0;
		end else if (load) begin
			multiplicand <= operandA;
			accHigh <= '0;
			accLow <= operandB;
			guard <= 1'b0;
		end else if (accumulate) begin
			accHigh <= sum;
		end else if (shift) begin
			{accHigh, accLow, guard} <= shifted;
		end
	end

	// two low multiplier bits plus the bit shifted out last
	assign window = {accLow[1:0], guard};

	// extra sign bits drop out, the result always fits in 16 bits
	assign product.full = {accHigh[OperandWidth-1:0], accLow};

endmodule

// File: hdl/axiLiteRegs.sv
`timescale 1ns/1ps

module axiLiteRegs import boothPkg::*, busPkg::*; (
	input logic CLK,
	input logic RESET,
	input logic awvalid,
	output logic awready,
	input logic [AddrWidth-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [DataWidth-1:0] wdata,
	output logic bvalid,
	input logic bready,
	output axiResp_t bresp,
	input logic arvalid,
	output logic arready,
	input logic [AddrWidth-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [DataWidth-1:0] rdata,
	output axiResp_t rresp,
	input logic busy,
	input logic done,
	input product_t product,
	output logic start,
	output operand_t operandA,
	output operand_t operandB
);

	logic writeReady;
	logic writeFire;
	logic writeMapped;
	logic readFire;
	logic doneFlag;
	logic [DataWidth-1:0] readData;
	axiResp_t readResp;

	// address and data accepted in the same cycle
	assign awready = writeReady;
	assign wready = writeReady;
	assign writeFire = awvalid && wvalid && writeReady;
	assign readFire = arvalid && arready;

	always_comb begin
		case (awaddr)
			regOperandA, regOperandB, regControl, regStatus,
			regProduct, regProductHigh, regProductLow: writeMapped = 1'b1;
			default: writeMapped = 1'b0;
		endcase
	end

	// write channel, one transfer in flight at a time
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			writeReady <= 1'b0;
			bvalid <= 1'b0;
			bresp <= respOkay;
		end else begin
			writeReady <= awvalid && wvalid && !writeReady && !bvalid;
			if (writeFire) begin
				bvalid <= 1'b1;
				bresp <= writeMapped ? respOkay : respSlvErr;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			operandA <= '0;
			operandB <= '0;
			start <= 1'b0;
			doneFlag <= 1'b0;
		end else begin
			// start while busy is dropped
			start <= writeFire && (awaddr == regControl) && wdata[0] && !busy;
			if (writeFire && (awaddr == regOperandA)) begin
				operandA <= wdata[OperandWidth-1:0];
			end
			if (writeFire && (awaddr == regOperandB)) begin
				operandB <= wdata[OperandWidth-1:0];
			end
			// sticky until the next accepted start
			if (start) begin
				doneFlag <= 1'b0;
			end else if (done) begin
				doneFlag <= 1'b1;
			end
		end
	end

	always_comb begin
		readData = '0;
		readResp = respOkay;
		case (araddr)
			regOperandA: readData[OperandWidth-1:0] = operandA;
			regOperandB: readData[OperandWidth-1:0] = operandB;
			regControl: readData = '0;
			regStatus: readData[1:0] = {doneFlag, busy};
			regProduct: begin
				readData = {
					{(DataWidth-ProductWidth){product.full[ProductWidth-1]}},
					product.full
				};
			end
			regProductHigh: readData[OperandWidth-1:0] = product.bytes.high;
			regProductLow: readData[OperandWidth-1:0] = product.bytes.low;
			default: readResp = respSlvErr;
		endcase
	end

	// read channel, data held until rready
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= respOkay;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (readFire) begin
				rvalid <= 1'b1;
				rdata <= readData;
				rresp <= readResp;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

endmodule

// File: hdl/multiplierTop.sv
`timescale 1ns/1ps

module multiplierTop import boothPkg::*, busPkg::*; (
	input logic CLK,
	input logic RESET,
	input logic awvalid,
	output logic awready,
	input logic [AddrWidth-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [DataWidth-1:0] wdata,
	output logic bvalid,
	input logic bready,
	output axiResp_t bresp,
	input logic arvalid,
	output logic arready,
	input logic [AddrWidth-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [DataWidth-1:0] rdata,
	output axiResp_t rresp
);

	logic start;
	logic busy;
	logic done;
	logic load;
	logic accumulate;
	logic shift;
	logic [2:0] window;
	boothAction_t action;
	operand_t operandA;
	operand_t operandB;
	product_t product;

	// bus side register block
	axiLiteRegs i_regs (
		.CLK(CLK),
		.RESET(RESET),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.busy(busy),
		.done(done),
		.product(product),
		.start(start),
		.operandA(operandA),
		.operandB(operandB)
	);

	boothControl i_control (
		.CLK(CLK),
		.RESET(RESET),
		.start(start),
		.window(window),
		.load(load),
		.accumulate(accumulate),
		.shift(shift),
		.busy(busy),
		.done(done),
		.action(action)
	);

	boothDatapath i_datapath (
		.CLK(CLK),
		.RESET(RESET),
		.load(load),
		.accumulate(accumulate),
		.shift(shift),
		.action(action),
		.operandA(operandA),
		.operandB(operandB),
		.window(window),
		.product(product)
	);

endmodule

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic CLK,
	output logic RESET
);

	// 20 ns period
	initial begin
		CLK = 1'b0;
		forever begin
			#10 CLK = ~CLK;
		end
	end

	// reset held for 16 cycles, released on a falling edge
	initial begin
		RESET = 1'b0;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b1;
	end

endmodule

// File: test/multiplierTb.sv
`timescale 1ns/1ps

module multiplierTb
	import boothPkg::*, busPkg::*;
();

	localparam int patternCount = 18;
	localparam int handshakeLimit = 20;
	localparam int pollLimit = 40;
	localparam int resetLimit = 40;
	localparam logic [AddrWidth-1:0] unmappedAddr = 5'h1C;

	logic CLK;
	logic RESET;
	logic awvalid;
	logic awready;
	logic [AddrWidth-1:0] awaddr;
	logic wvalid;
	logic wready;
	logic [DataWidth-1:0] wdata;
	logic bvalid;
	logic bready;
	axiResp_t bresp;
	logic arvalid;
	logic arready;
	logic [AddrWidth-1:0] araddr;
	logic rvalid;
	logic rready;
	logic [DataWidth-1:0] rdata;
	axiResp_t rresp;

	// operand A, operand B, expected product per pattern
	logic [ProductWidth-1:0] patterns [0:3*patternCount-1];
	logic [31:0] lcgState;

	clockGen i_clock (
		.CLK(CLK),
		.RESET(RESET)
	);

	multiplierTop i_dut (
		.CLK(CLK),
		.RESET(RESET),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp)
	);

	// ready delay of 0 to 7 cycles
	function automatic logic [2:0] nextDelay();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[18:16];
	endfunction

	task automatic abortRun();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic checkProduct(string what, product_t expected, product_t actual);
		if (actual.full !== expected.full) begin
			$display("Error at %0t: %s expected %h, got %h",
				$time, what, expected.full, actual.full);
			abortRun();
		end
	endtask

	task automatic checkResp(string what, axiResp_t expected, axiResp_t actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected %s, got %s (%b)",
				$time, what, expected.name(), actual.name(), actual);
			abortRun();
		end
	endtask

	task automatic checkStatus(string what, logic [1:0] expected, logic [1:0] actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected done/busy %b, got %b",
				$time, what, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkData(string what, logic [DataWidth-1:0] expected,
		logic [DataWidth-1:0] actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected %h, got %h",
				$time, what, expected, actual);
			abortRun();
		end
	endtask

	task automatic axiWrite(
		input logic [AddrWidth-1:0] addr,
		input logic [DataWidth-1:0] data,
		output axiResp_t resp
	);
		int waitCount;
		int delay;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		waitCount = 0;
		@(negedge CLK);
		// ready seen here means the transfer happens on the next rising edge
		while (!(awready === 1'b1 && wready === 1'b1)) begin
			waitCount++;
			if (waitCount > handshakeLimit) begin
				$display("write address and data never accepted by DUT");
				abortRun();
			end
			@(negedge CLK);
		end
		@(negedge CLK);
		awvalid = 1'b0;
		wvalid = 1'b0;
		waitCount = 0;
		while (bvalid !== 1'b1) begin
			waitCount++;
			if (waitCount > handshakeLimit) begin
				$display("no write response from DUT");
				abortRun();
			end
			@(negedge CLK);
		end
		resp = bresp;
		delay = nextDelay();
		repeat (delay) begin
			@(negedge CLK);
			if (bvalid !== 1'b1) begin
				$display("write response withdrawn before bready");
				abortRun();
			end
			checkResp("bresp while held", resp, bresp);
		end
		bready = 1'b1;
		@(negedge CLK);
		bready = 1'b0;
	endtask

	task automatic axiRead(
		input logic [AddrWidth-1:0] addr,
		output logic [DataWidth-1:0] data,
		output axiResp_t resp
	);
		int waitCount;
		int delay;
		araddr = addr;
		arvalid = 1'b1;
		waitCount = 0;
		@(negedge CLK);
		while (arready !== 1'b1) begin
			waitCount++;
			if (waitCount > handshakeLimit) begin
				$display("read address never accepted by DUT");
				abortRun();
			end
			@(negedge CLK);
		end
		@(negedge CLK);
		arvalid = 1'b0;
		waitCount = 0;
		while (rvalid !== 1'b1) begin
			waitCount++;
			if (waitCount > handshakeLimit) begin
				$display("no read data from DUT");
				abortRun();
			end
			@(negedge CLK);
		end
		data = rdata;
		resp = rresp;
		delay = nextDelay();
		// data and response must hold still while rready stays low
		repeat (delay) begin
			@(negedge CLK);
			if (rvalid !== 1'b1) begin
				$display("read data withdrawn before rready");
				abortRun();
			end
			checkData("rdata while held", data, rdata);
			checkResp("rresp while held", resp, rresp);
		end
		rready = 1'b1;
		@(negedge CLK);
		rready = 1'b0;
	endtask

	task automatic writeReg(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
		axiResp_t resp;
		axiWrite(addr, data, resp);
		checkResp($sformatf("write response at %h", addr), respOkay, resp);
	endtask

	task automatic readReg(input logic [AddrWidth-1:0] addr, output logic [DataWidth-1:0] data);
		axiResp_t resp;
		axiRead(addr, data, resp);
		checkResp($sformatf("read response at %h", addr), respOkay, resp);
	endtask

	task automatic writeOperands(input logic [ProductWidth-1:0] aWord,
		input logic [ProductWidth-1:0] bWord);
		writeReg(regOperandA, DataWidth'(aWord[OperandWidth-1:0]));
		writeReg(regOperandB, DataWidth'(bWord[OperandWidth-1:0]));
	endtask

	task automatic waitDone();
		logic [DataWidth-1:0] status;
		int pollCount;
		pollCount = 0;
		readReg(regStatus, status);
		while (status[0] === 1'b1) begin
			// the start that made the unit busy has already cleared done
			checkStatus("status while busy", 2'b01, status[1:0]);
			pollCount++;
			if (pollCount > pollLimit) begin
				$display("multiplier stayed busy past the polling limit");
				abortRun();
			end
			readReg(regStatus, status);
		end
		checkStatus("status after busy dropped", 2'b10, status[1:0]);
	endtask

	task automatic checkProductReads(product_t expected);
		logic [DataWidth-1:0] word;
		logic [DataWidth-1:0] highWord;
		logic [DataWidth-1:0] lowWord;
		product_t got;
		readReg(regProduct, word);
		got.full = word[ProductWidth-1:0];
		checkProduct("regProduct", expected, got);
		checkData("regProduct sign extension",
			{{(DataWidth-ProductWidth){expected.full[ProductWidth-1]}}, expected.full}, word);
		// same product through the byte registers
		readReg(regProductHigh, highWord);
		readReg(regProductLow, lowWord);
		got.bytes.high = highWord[OperandWidth-1:0];
		got.bytes.low = lowWord[OperandWidth-1:0];
		checkProduct("regProductHigh and regProductLow", expected, got);
		checkData("regProductHigh upper bits", '0, highWord >> OperandWidth);
		checkData("regProductLow upper bits", '0, lowWord >> OperandWidth);
	endtask

	initial begin
		logic [DataWidth-1:0] data;
		axiResp_t resp;
		product_t expected;
		int waitCount;
		$timeformat(-9, 0, " ns", 0);
		lcgState = 32'he4a90afd;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		$readmemh("test/multPatterns.txt", patterns);
		if ($isunknown(patterns[3*patternCount-1])) begin
			$display("pattern file test/multPatterns.txt is missing or too short");
			abortRun();
		end

		waitCount = 0;
		while (RESET !== 1'b1) begin
			waitCount++;
			if (waitCount > resetLimit) begin
				$display("reset was never released");
				abortRun();
			end
			@(negedge CLK);
		end
		@(negedge CLK);

		readReg(regStatus, data);
		checkStatus("status after reset", 2'b00, data[1:0]);

		// unmapped offset in both directions
		axiWrite(unmappedAddr, 32'h0000_00ff, resp);
		checkResp("write to unmapped offset", respSlvErr, resp);
		axiRead(unmappedAddr, data, resp);
		checkResp("read from unmapped offset", respSlvErr, resp);
		checkData("read data from unmapped offset", '0, data);
		readReg(regStatus, data);
		checkStatus("status before first start", 2'b00, data[1:0]);

		for (int i = 0; i < patternCount; i++) begin
			expected.full = patterns[3*i+2];
			writeOperands(patterns[3*i], patterns[3*i+1]);
			writeReg(regControl, 32'h1);
			waitDone();
			checkProductReads(expected);
		end

		// second start and new operands land while the first pair is running
		expected.full = patterns[2];
		writeOperands(patterns[0], patterns[1]);
		writeReg(regControl, 32'h1);
		writeReg(regControl, 32'h1);
		writeOperands(patterns[6], patterns[7]);
		waitDone();
		checkProductReads(expected);

		$display("TEST OK");
		$finish;
	end

endmodule

// File: test/multPatterns.txt
// columns: operand A, operand B, expected signed product (hex)
// operands are 8-bit two's complement, product is 16-bit
03 05 000F
00 5A 0000
80 80 4000
FF FF 0001
7F 7F 3F01
80 7F C080
FF 01 FFFF
FE 03 FFFA
0C F6 FF88
F6 F6 0064
55 AA E372
80 FF 0080
12 34 03A8
C3 3C F1B4
7F FF FF81
64 9C D8F0
3B C7 F2DD
E0 20 FC00

// File: build.f
hdl/boothPkg.sv
hdl/busPkg.sv
hdl/boothControl.sv
hdl/boothDatapath.sv
hdl/axiLiteRegs.sv
hdl/multiplierTop.sv
test/clockGen.sv
test/multiplierTb.sv
